// ==== Makefile ====
# Verilator build and run for the camera pixel pipeline testbench

VERILATOR ?= verilator
TOP       ?= tb_camera_pipeline
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= TESTBENCH PASSED

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass line shows up in the output
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== bayer_demosaic.sv ====
`timescale 1ns/1ps
// Bayer to RGB conversion
// One RGB pixel per 2x2 block, even rows held in a line buffer
module bayer_demosaic
  import cam_params_pkg::*, pixel_types_pkg::*;
#(
  parameter int frame_width = default_frame_width
) (
  input  logic         ccd_pixel_clk,
  input  logic         hps_fpga_reset_n,
  input  raw_sample_t  cap_data,
  input  logic         cap_valid,
  input  pixel_count_t cap_x,
  input  pixel_count_t cap_y,
  output channel_t     rgb_red,
  output channel_t     rgb_green,
  output channel_t     rgb_blue,
  output logic         rgb_valid
);

  // Two samples per block column, frame_width samples in total
  localparam int buf_depth = frame_width / 2;
  localparam int idx_width = $clog2(buf_depth);

  // Layout
  //   even row  G1 R G1 R ...
  //   odd row   B  G2 B  G2 ...

  raw_sample_t          buf_g1  [buf_depth];   // G1 of each block
  raw_sample_t          buf_red [buf_depth];   // R of each block
  raw_sample_t          col_hold;              // Even-column sample of this row
  logic [idx_width-1:0] blk_idx;
  logic [raw_width:0]   green_sum;             // One extra bit for carry
  logic                 block_done;

  assign blk_idx    = cap_x[idx_width:1];   // Block column
  assign block_done = cap_valid & cap_x[0] & cap_y[0];
  assign green_sum  = {1'b0, buf_g1[blk_idx]} + {1'b0, cap_data};

  // ======================================
  // Line buffer and sample hold
  // ======================================
  always_ff @(posedge ccd_pixel_clk) begin
    if (cap_valid) begin
      if (!cap_x[0]) begin
        col_hold <= cap_data;   // G1 on even rows, B on odd rows
      end else if (!cap_y[0]) begin
        buf_g1[blk_idx]  <= col_hold;
        buf_red[blk_idx] <= cap_data;
      end
    end
  end

  // ======================================
  // Pixel output
  // ======================================
  always_ff @(posedge ccd_pixel_clk) begin
    if (block_done) begin
      rgb_red   <= buf_red[blk_idx];
      rgb_green <= green_sum[raw_width:1];   // Mean of G1 and G2, truncated
      rgb_blue  <= col_hold;
    end
  end

  always_ff @(posedge ccd_pixel_clk) begin
    if (!hps_fpga_reset_n) begin
      rgb_valid <= 1'b0;
    end else begin
      rgb_valid <= block_done;   // One cycle after the G2 sample
    end
  end

endmodule

// ==== cam_params_pkg.sv ====
// Camera pipeline constants
// Sensor widths, default frame size, output queue depth and hue arithmetic
package cam_params_pkg;

  // ======================================
  // Sensor and channel widths
  // ======================================
  localparam int raw_width    = 12;  // Sensor sample
  localparam int chan_width   = 12;  // RGB channel after demosaic
  localparam int hue_in_width = 8;   // Upper channel bits seen by hue
  localparam int quant_bits   = 5;   // Bits kept per channel in colour mode
  localparam int word_width   = 16;  // Output word

  // Counters
  localparam int count_width       = 12;  // Column and row index
  localparam int frame_count_width = 32;

  // ======================================
  // Frame geometry and buffering
  // ======================================
  localparam int default_frame_width  = 1280;  // Native sensor size
  localparam int default_frame_height = 960;
  localparam int queue_depth          = 4;     // Output queue entries

  // ======================================
  // Hue arithmetic
  // ======================================
  localparam int hue_sector     = 43;   // One sixth of the 256 circle
  localparam int hue_green_base = 85;
  localparam int hue_blue_base  = 171;
  localparam int hue_latency    = 3;    // Pipeline stages

endpackage

// ==== camera_pipeline_top.sv ====
`timescale 1ns/1ps
// Camera pixel pipeline top level
// Capture, demosaic, colour and hue branches, output queue
module camera_pipeline_top
  import cam_params_pkg::*, pixel_types_pkg::*;
#(
  parameter int frame_width  = default_frame_width,
  parameter int frame_height = default_frame_height
) (
  input  logic         ccd_pixel_clk,
  input  logic         hps_fpga_reset_n,
  input  raw_sample_t  pixel_data,
  input  logic         frame_valid,
  input  logic         line_valid,
  input  logic         capture_start,
  input  logic         hue_mode,
  input  logic [2:0]   channel_enable,
  input  logic         out_ready,
  output pixel_word_t  out_data,
  output logic         out_valid,
  output logic         overflow,
  output frame_count_t frame_count
);

  raw_sample_t  cap_data;
  logic         cap_valid;
  pixel_count_t cap_x;
  pixel_count_t cap_y;
  channel_t     rgb_red;
  channel_t     rgb_green;
  channel_t     rgb_blue;
  logic         rgb_valid;
  pixel_word_t  quant_word;
  logic         quant_valid;
  hue_t         hue;
  logic         hue_valid;

  frame_capture #(.frame_width(frame_width), .frame_height(frame_height)) u_capture (
    .ccd_pixel_clk, .hps_fpga_reset_n, .pixel_data, .frame_valid, .line_valid,
    .capture_start, .cap_data, .cap_valid, .cap_x, .cap_y, .frame_count
  );

  bayer_demosaic #(.frame_width(frame_width)) u_demosaic (
    .ccd_pixel_clk, .hps_fpga_reset_n, .cap_data, .cap_valid, .cap_x, .cap_y,
    .rgb_red, .rgb_green, .rgb_blue, .rgb_valid
  );

  // Both branches run side by side
  color_quantizer u_quant (
    .ccd_pixel_clk, .hps_fpga_reset_n, .rgb_red, .rgb_green, .rgb_blue, .rgb_valid,
    .channel_enable, .quant_word, .quant_valid
  );

  rgb_to_hue u_hue (
    .ccd_pixel_clk,
    .hps_fpga_reset_n,
    .rgb_red   (rgb_red[chan_width-1 -: hue_in_width]),   // Upper 8 bits only
    .rgb_green (rgb_green[chan_width-1 -: hue_in_width]),
    .rgb_blue  (rgb_blue[chan_width-1 -: hue_in_width]),
    .rgb_valid,
    .hue,
    .hue_valid
  );

  output_selector u_select (
    .ccd_pixel_clk, .hps_fpga_reset_n, .hue_mode, .quant_word, .quant_valid,
    .hue, .hue_valid, .out_ready, .out_data, .out_valid, .overflow
  );

endmodule

// ==== color_quantizer.sv ====
`timescale 1ns/1ps
// Colour quantizer
// Packs the top 5 bits of each enabled channel into a 15-bit word
module color_quantizer
  import cam_params_pkg::*, pixel_types_pkg::*;
(
  input  logic        ccd_pixel_clk,
  input  logic        hps_fpga_reset_n,
  input  channel_t    rgb_red,
  input  channel_t    rgb_green,
  input  channel_t    rgb_blue,
  input  logic        rgb_valid,
  input  logic [2:0]  channel_enable,   // R G B, msb first
  output pixel_word_t quant_word,
  output logic        quant_valid
);

  logic [quant_bits-1:0] red_field;
  logic [quant_bits-1:0] green_field;
  logic [quant_bits-1:0] blue_field;

  // Truncate then mask
  assign red_field   = rgb_red[chan_width-1 -: quant_bits] & {quant_bits{channel_enable[2]}};
  assign green_field = rgb_green[chan_width-1 -: quant_bits] & {quant_bits{channel_enable[1]}};
  assign blue_field  = rgb_blue[chan_width-1 -: quant_bits] & {quant_bits{channel_enable[0]}};

  always_ff @(posedge ccd_pixel_clk) begin
    quant_word <= pixel_word_t'({red_field, green_field, blue_field});   // Bit 15 stays 0
  end

  always_ff @(posedge ccd_pixel_clk) begin
    if (!hps_fpga_reset_n) quant_valid <= 1'b0;
    else quant_valid <= rgb_valid;
  end

endmodule

// ==== filelist.f ====
cam_params_pkg.sv
pixel_types_pkg.sv
frame_capture.sv
bayer_demosaic.sv
color_quantizer.sv
rgb_to_hue.sv
output_selector.sv
camera_pipeline_top.sv
tb_clock_gen.sv
tb_camera_pipeline.sv

// ==== frame_capture.sv ====
`timescale 1ns/1ps
// Camera front end
// Registers sensor inputs, gates capture on the start switch, counts x/y/frames
module frame_capture
  import cam_params_pkg::*, pixel_types_pkg::*;
#(
  parameter int frame_width  = default_frame_width,
  parameter int frame_height = default_frame_height
) (
  input  logic         ccd_pixel_clk,
  input  logic         hps_fpga_reset_n,
  input  raw_sample_t  pixel_data,
  input  logic         frame_valid,
  input  logic         line_valid,
  input  logic         capture_start,   // Start switch
  output raw_sample_t  cap_data,
  output logic         cap_valid,
  output pixel_count_t cap_x,
  output pixel_count_t cap_y,
  output frame_count_t frame_count
);

  raw_sample_t  data_q;
  logic         fv_q;
  logic         lv_q;
  logic         fv_prev;
  logic         lv_prev;
  logic         capturing;   // Armed for the current frame
  logic         fv_rise;
  logic         fv_fall;
  logic         lv_fall;
  logic         arm_now;
  pixel_count_t col_cnt;
  pixel_count_t row_cnt;

  // ======================================
  // Input registers
  // ======================================
  always_ff @(posedge ccd_pixel_clk) begin
    data_q <= pixel_data;
  end

  always_ff @(posedge ccd_pixel_clk) begin
    if (!hps_fpga_reset_n) begin
      fv_q    <= 1'b0;
      lv_q    <= 1'b0;
      fv_prev <= 1'b0;
      lv_prev <= 1'b0;
    end else begin
      fv_q    <= frame_valid;
      lv_q    <= line_valid;
      fv_prev <= fv_q;   // Edge detect on registered strobes
      lv_prev <= lv_q;
    end
  end

  assign fv_rise = fv_q & ~fv_prev;
  assign fv_fall = ~fv_q & fv_prev;
  assign lv_fall = ~lv_q & lv_prev;
  // First line may start on the frame edge itself
  assign arm_now = capturing | (fv_rise & capture_start);

  // ======================================
  // Capture gate and counters
  // ======================================
  always_ff @(posedge ccd_pixel_clk) begin
    if (!hps_fpga_reset_n) begin
      capturing   <= 1'b0;
      cap_valid   <= 1'b0;
      frame_count <= '0;
      col_cnt     <= '0;
      row_cnt     <= '0;
    end else begin
      if (fv_fall) capturing <= 1'b0;                       // Whole frame then stop
      else if (fv_rise && capture_start) capturing <= 1'b1;
      if (fv_fall && capturing) frame_count <= frame_count + 1'b1;
      cap_valid <= fv_q & lv_q & arm_now;
      if (!lv_q) col_cnt <= '0;   // Idle between lines
      else col_cnt <= col_cnt + 1'b1;
      if (!fv_q) row_cnt <= '0;   // Idle between frames
      else if (lv_fall) row_cnt <= row_cnt + 1'b1;
    end
  end

  always_ff @(posedge ccd_pixel_clk) begin
    cap_data <= data_q;
    cap_x    <= col_cnt;
    cap_y    <= row_cnt;
  end

  // Sensor must not overrun the configured geometry
  assert property (@(posedge ccd_pixel_clk) disable iff (!hps_fpga_reset_n)
    cap_valid |-> (cap_x < frame_width) && (cap_y < frame_height))
    else $error("cap_x/cap_y outside frame");

endmodule

// ==== output_selector.sv ====
`timescale 1ns/1ps
// Output selector
// Mode mux into a small queue with valid/ready output and sticky overflow
module output_selector
  import cam_params_pkg::*, pixel_types_pkg::*;
(
  input  logic        ccd_pixel_clk,
  input  logic        hps_fpga_reset_n,
  input  logic        hue_mode,      // High selects the hue branch
  input  pixel_word_t quant_word,
  input  logic        quant_valid,
  input  hue_t        hue,
  input  logic        hue_valid,
  input  logic        out_ready,
  output pixel_word_t out_data,
  output logic        out_valid,
  output logic        overflow
);

  localparam int                ptr_width  = $clog2(queue_depth);
  localparam logic [ptr_width:0] full_level = (ptr_width + 1)'(queue_depth);

  pixel_word_t          queue_mem [queue_depth];
  logic [ptr_width-1:0] wr_ptr;
  logic [ptr_width-1:0] rd_ptr;
  logic [ptr_width:0]   fill;        // Words held
  logic                 sel_valid;
  pixel_word_t          sel_word;
  logic                 full;
  logic                 push;
  logic                 pop;

  // Branch select, hue zero-extended into the low byte
  assign sel_valid = hue_mode ? hue_valid : quant_valid;
  assign sel_word  = hue_mode ? pixel_word_t'(hue) : quant_word;

  assign full      = (fill == full_level);
  assign push      = sel_valid & ~full;   // Newest word dropped when full
  assign pop       = out_valid & out_ready;
  assign out_valid = (fill != '0);
  assign out_data  = queue_mem[rd_ptr];

  always_ff @(posedge ccd_pixel_clk) begin
    if (push) queue_mem[wr_ptr] <= sel_word;
  end

  always_ff @(posedge ccd_pixel_clk) begin
    if (!hps_fpga_reset_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fill     <= '0;
      overflow <= 1'b0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;   // Power-of-two wrap
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
      if (sel_valid && full) overflow <= 1'b1;   // Sticky until reset
    end
  end

  // Stalled word must hold
  assert property (@(posedge ccd_pixel_clk) disable iff (!hps_fpga_reset_n)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
    else $error("out_data changed while stalled");

endmodule

// ==== pixel_types_pkg.sv ====
// Pixel path data types
// Raw samples, colour channels, hue, packed output words and counters
package pixel_types_pkg;

  import cam_params_pkg::*;

  // Sensor side
  typedef logic [raw_width-1:0] raw_sample_t;

  // Colour side
  typedef logic [chan_width-1:0] channel_t;
  typedef logic [7:0]            hue_t;       // Full circle in 256 steps

  // Output word, colour or hue
  typedef logic [word_width-1:0] pixel_word_t;

  // Position and frame counters
  typedef logic [count_width-1:0]       pixel_count_t;
  typedef logic [frame_count_width-1:0] frame_count_t;

endpackage

// ==== rgb_to_hue.sv ====
`timescale 1ns/1ps
// RGB to hue
// Three-stage pipeline, 8-bit hue, one pixel accepted per cycle
module rgb_to_hue
  import cam_params_pkg::*, pixel_types_pkg::*;
(
  input  logic                    ccd_pixel_clk,
  input  logic                    hps_fpga_reset_n,
  input  logic [hue_in_width-1:0] rgb_red,
  input  logic [hue_in_width-1:0] rgb_green,
  input  logic [hue_in_width-1:0] rgb_blue,
  input  logic                    rgb_valid,
  output hue_t                    hue,
  output logic                    hue_valid
);

  localparam int scaled_width = hue_in_width + 8;   // 43 * 255 with sign

  typedef logic [hue_in_width-1:0] hchan_t;
  typedef enum logic [1:0] {sect_red, sect_green, sect_blue} sector_t;

  // Stage 1 max/min/sector
  logic    red_top;
  logic    green_top;
  hchan_t  min_rg;
  logic    s1_valid;
  hchan_t  s1_r;
  hchan_t  s1_g;
  hchan_t  s1_b;
  hchan_t  s1_max;
  hchan_t  s1_min;
  sector_t s1_sector;
  // Stage 2 scaled difference
  hchan_t                          delta;
  logic signed [hue_in_width:0]    diff;
  logic                            s2_valid;
  logic                            s2_grey;
  logic signed [scaled_width-1:0]  s2_scaled;
  logic signed [hue_in_width:0]    s2_divisor;
  hue_t                            s2_base;
  // Stage 3 divide
  logic signed [scaled_width-1:0]  quot;

  // ======================================
  // Stage 1
  // ======================================
  assign red_top   = (rgb_red >= rgb_green) && (rgb_red >= rgb_blue);   // Red wins ties
  assign green_top = !red_top && (rgb_green >= rgb_blue);               // Then green
  assign min_rg    = (rgb_red < rgb_green) ? rgb_red : rgb_green;

  always_ff @(posedge ccd_pixel_clk) begin
    s1_r      <= rgb_red;
    s1_g      <= rgb_green;
    s1_b      <= rgb_blue;
    s1_max    <= red_top ? rgb_red : (green_top ? rgb_green : rgb_blue);
    s1_min    <= (min_rg < rgb_blue) ? min_rg : rgb_blue;
    s1_sector <= red_top ? sect_red : (green_top ? sect_green : sect_blue);
  end

  // ======================================
  // Stage 2
  // ======================================
  assign delta = s1_max - s1_min;

  always_comb begin
    case (s1_sector)
      sect_red:   diff = $signed({1'b0, s1_g}) - $signed({1'b0, s1_b});
      sect_green: diff = $signed({1'b0, s1_b}) - $signed({1'b0, s1_r});
      default:    diff = $signed({1'b0, s1_r}) - $signed({1'b0, s1_g});
    endcase
  end

  always_ff @(posedge ccd_pixel_clk) begin
    s2_grey    <= (delta == '0);
    s2_scaled  <= scaled_width'(hue_sector * diff);
    s2_divisor <= (delta == '0) ? (hue_in_width + 1)'(1) : $signed({1'b0, delta});  // No /0
    case (s1_sector)
      sect_red:   s2_base <= '0;
      sect_green: s2_base <= hue_t'(hue_green_base);
      default:    s2_base <= hue_t'(hue_blue_base);
    endcase
  end

  // ======================================
  // Stage 3
  // ======================================
  assign quot = s2_scaled / s2_divisor;   // Signed, toward zero

  always_ff @(posedge ccd_pixel_clk) begin
    hue <= s2_grey ? '0 : s2_base + hue_t'(quot);   // Wraps mod 256
  end

  // Valid chain
  always_ff @(posedge ccd_pixel_clk) begin
    if (!hps_fpga_reset_n) begin
      s1_valid  <= 1'b0;
      s2_valid  <= 1'b0;
      hue_valid <= 1'b0;
    end else begin
      s1_valid  <= rgb_valid;
      s2_valid  <= s1_valid;
      hue_valid <= s2_valid;
    end
  end

  // Fixed latency in both directions
  assert property (@(posedge ccd_pixel_clk) disable iff (!hps_fpga_reset_n)
    rgb_valid |-> ##hue_latency hue_valid)
    else $error("hue_valid missing after rgb_valid");
  assert property (@(posedge ccd_pixel_clk) disable iff (!hps_fpga_reset_n)
    hue_valid |-> $past(rgb_valid, hue_latency))
    else $error("hue_valid without rgb_valid");

endmodule

// ==== tb_camera_pipeline.sv ====
`timescale 1ns/1ps
// Camera pipeline testbench
// Random and directed Bayer frames against a reference model of the pixel path
module tb_camera_pipeline
  import cam_params_pkg::*, pixel_types_pkg::*;
();

  // ========================================
  // Geometry and run length
  // ========================================
  localparam int test_w       = 8;
  localparam int test_h       = 4;
  localparam int blocks       = (test_w / 2) * (test_h / 2);   // Words per frame
  localparam int frame_cycles = 4 + 2 + test_h * (test_w + 2) + 4;
  localparam int total_frames = 17;   // Summed over all tests
  localparam int cycle_limit  = 2 * total_frames * frame_cycles + 200;
  localparam int flush_cycles = 8;    // Hue path latency plus one

  logic         ccd_pixel_clk;
  logic         hps_fpga_reset_n;
  raw_sample_t  pixel_data;
  logic         frame_valid;
  logic         line_valid;
  logic         capture_start;
  logic         hue_mode;
  logic [2:0]   channel_enable;
  logic         out_ready;
  pixel_word_t  out_data;
  logic         out_valid;
  logic         overflow;
  frame_count_t frame_count;

  raw_sample_t  frame_buf [test_h][test_w];   // Frame about to be sent
  pixel_word_t  frame_words [$];              // Model output for that frame
  pixel_word_t  exp_q [$];                    // Words still owed by the DUT
  pixel_word_t  exp_word;
  pixel_word_t  mask_word;
  frame_count_t frames_before;
  int           cycle_count = 0;
  int           error_count = 0;
  int           errors_at_start = 0;
  int           pass_count = 0;
  int           fail_count = 0;
  int           test_num = 0;

  tb_clock_gen #(.period(100), .reset_cycles(2)) u_clk (
    .ccd_pixel_clk, .hps_fpga_reset_n
  );

  camera_pipeline_top #(.frame_width(test_w), .frame_height(test_h)) uut (
    .ccd_pixel_clk, .hps_fpga_reset_n, .pixel_data, .frame_valid, .line_valid,
    .capture_start, .hue_mode, .channel_enable, .out_ready,
    .out_data, .out_valid, .overflow, .frame_count
  );

  // ========================================
  // Reference model
  // ========================================
  function automatic pixel_word_t colour_word(channel_t r, channel_t g, channel_t b,
                                              logic [2:0] en);
    logic [4:0] rf;
    logic [4:0] gf;
    logic [4:0] bf;
    rf = en[2] ? r[11:7] : 5'd0;   // Top five bits per channel
    gf = en[1] ? g[11:7] : 5'd0;
    bf = en[0] ? b[11:7] : 5'd0;
    return {1'b0, rf, gf, bf};
  endfunction

  function automatic pixel_word_t hue_word(channel_t r12, channel_t g12, channel_t b12);
    int r;
    int g;
    int b;
    int mx;
    int mn;
    int h;
    r  = int'(r12[11:4]);
    g  = int'(g12[11:4]);
    b  = int'(b12[11:4]);
    mx = (r > g) ? r : g;
    mx = (b > mx) ? b : mx;
    mn = (r < g) ? r : g;
    mn = (b < mn) ? b : mn;
    if (mx == mn) h = 0;                                     // Grey
    else if (r == mx) h = hue_sector * (g - b) / (mx - mn);  // Red wins ties
    else if (g == mx) h = hue_green_base + hue_sector * (b - r) / (mx - mn);
    else h = hue_blue_base + hue_sector * (r - g) / (mx - mn);
    return pixel_word_t'(h & 255);   // Mod 256, upper byte zero
  endfunction

  // One word per 2x2 block, raster order
  task automatic model_frame();
    channel_t           g1;
    channel_t           g2;
    channel_t           red;
    channel_t           blue;
    channel_t           grn;
    logic [raw_width:0] gsum;
    frame_words.delete();
    for (int by = 0; by < test_h / 2; by++) begin
      for (int bx = 0; bx < test_w / 2; bx++) begin
        g1   = frame_buf[2*by][2*bx];
        red  = frame_buf[2*by][2*bx+1];
        blue = frame_buf[2*by+1][2*bx];
        g2   = frame_buf[2*by+1][2*bx+1];
        gsum = {1'b0, g1} + {1'b0, g2};
        grn  = gsum[raw_width:1];   // Mean, truncated
        if (hue_mode) frame_words.push_back(hue_word(red, grn, blue));
        else frame_words.push_back(colour_word(red, grn, blue, channel_enable));
      end
    end
  endtask

  task automatic expect_words(int keep);
    for (int i = 0; i < keep && i < frame_words.size(); i++) begin
      exp_q.push_back(frame_words[i]);   // Oldest words survive an overflow
    end
  endtask

  // ========================================
  // Frame content
  // ========================================
  task automatic fill_random();
    for (int y = 0; y < test_h; y++) begin
      for (int x = 0; x < test_w; x++) frame_buf[y][x] = raw_sample_t'($urandom);
    end
  endtask

  task automatic set_block(int idx, channel_t r, channel_t g, channel_t b);
    int bx;
    int by;
    bx = idx % (test_w / 2);
    by = idx / (test_w / 2);
    frame_buf[2*by][2*bx]     = g;   // G1
    frame_buf[2*by][2*bx+1]   = r;
    frame_buf[2*by+1][2*bx]   = b;
    frame_buf[2*by+1][2*bx+1] = g;   // G2 equal so green is exact
  endtask

  task automatic fill_hue_cases();
    set_block(0, 12'h808, 12'h808, 12'h808);   // Grey
    set_block(1, 12'hfff, 12'h000, 12'h000);   // Pure red
    set_block(2, 12'h000, 12'hfff, 12'h000);   // Pure green
    set_block(3, 12'h000, 12'h000, 12'hfff);   // Pure blue
    set_block(4, 12'hfff, 12'hfff, 12'h000);   // Red and green tie
    set_block(5, 12'hfff, 12'h000, 12'h800);   // Negative, wraps
    set_block(6, 12'h000, 12'hfff, 12'hfff);   // Green and blue tie
    set_block(7, 12'h400, 12'h100, 12'hf00);
  endtask

  // ========================================
  // Stimulus
  // ========================================
  task automatic drive_cycle(logic fv, logic lv, raw_sample_t data);
    frame_valid = fv;
    line_valid  = lv;
    pixel_data  = data;
    @(posedge ccd_pixel_clk);
    #10;
  endtask

  // Start switch dropped at stop_row when it is not negative
  task automatic send_frame(int stop_row);
    repeat (4) drive_cycle(1'b0, 1'b0, '0);
    repeat (2) drive_cycle(1'b1, 1'b0, '0);   // Frame valid leads the first line
    for (int y = 0; y < test_h; y++) begin
      if (y == stop_row) capture_start = 1'b0;
      for (int x = 0; x < test_w; x++) drive_cycle(1'b1, 1'b1, frame_buf[y][x]);
      repeat (2) drive_cycle(1'b1, 1'b0, '0);
    end
    repeat (4) drive_cycle(1'b0, 1'b0, '0);
  endtask

  // Captured only if the switch is on at frame start
  task automatic run_frame(int keep, int stop_row);
    if (capture_start) begin
      model_frame();
      expect_words(keep);
    end
    send_frame(stop_row);
  endtask

  task automatic drain();
    while (exp_q.size() != 0) @(posedge ccd_pixel_clk);
    repeat (flush_cycles) @(posedge ccd_pixel_clk);   // Catch stray words
    #10;
  endtask

  task automatic check_frames(frame_count_t want);
    assert (frame_count == want)
      else begin
        $display("Error: frame_count expected 0x%h got 0x%h", want, frame_count);
        error_count++;
      end
  endtask

  task automatic begin_test();
    test_num++;
    errors_at_start = error_count;
  endtask

  task automatic end_test(string name);
    if (error_count == errors_at_start) begin
      pass_count++;
      $display("Test %0d %s: ok", test_num, name);
    end else begin
      fail_count++;
      $display("Test %0d %s: %0d errors", test_num, name, error_count - errors_at_start);
    end
  endtask

  // ========================================
  // Output checks
  // ========================================
  always @(posedge ccd_pixel_clk) begin
    if (hps_fpga_reset_n && out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        $display("Output word 0x%h accepted while no word was expected", out_data);
        error_count++;
      end else begin
        exp_word = exp_q.pop_front();
        assert (out_data == exp_word)
          else begin
            $display("Error: out_data expected 0x%h got 0x%h", exp_word, out_data);
            error_count++;
          end
      end
      mask_word = {1'b0, {5{channel_enable[2]}}, {5{channel_enable[1]}},
                   {5{channel_enable[0]}}};
      if (hue_mode) begin
        assert (out_data[15:8] == 8'h00)   // Hue sits in the low byte
          else begin
            $display("Error: out_data[15:8] expected 0x00 got 0x%h", out_data[15:8]);
            error_count++;
          end
      end else begin
        assert ((out_data & ~mask_word) == '0)
          else begin
            $display("Error: out_data disabled fields expected 0x0000 got 0x%h",
                     out_data & ~mask_word);
            error_count++;
          end
      end
    end
  end

  // Stalled word holds
  assert property (@(posedge ccd_pixel_clk) disable iff (!hps_fpga_reset_n)
    (out_valid && !out_ready) |=> $stable(out_data))
    else begin
      $display("Error: out_data changed while stalled, now 0x%h", out_data);
      error_count++;
    end

  // Overflow sticky until reset
  assert property (@(posedge ccd_pixel_clk) disable iff (!hps_fpga_reset_n)
    overflow |=> overflow)
    else begin
      $display("Error: overflow expected 0x1 got 0x%h", overflow);
      error_count++;
    end

  // Run limit
  always @(posedge ccd_pixel_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Run stopped after %0d cycles, output never drained", cycle_count);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // ========================================
  // Test sequence
  // ========================================
  initial begin
    void'($urandom(4681));
    pixel_data     = '0;
    frame_valid    = 1'b0;
    line_valid     = 1'b0;
    capture_start  = 1'b0;
    hue_mode       = 1'b0;
    channel_enable = 3'b111;
    out_ready      = 1'b1;
    wait (hps_fpga_reset_n === 1'b1);
    @(posedge ccd_pixel_clk);
    #10;

    begin_test();
    repeat (2) begin   // Switch off, nothing captured
      fill_random();
      run_frame(blocks, -1);
    end
    drain();
    check_frames('0);
    capture_start = 1'b1;
    fill_random();
    run_frame(blocks, -1);
    drain();
    check_frames(frame_count_t'(1));
    end_test("capture gating");

    begin_test();
    repeat (2) begin
      fill_random();
      run_frame(blocks, -1);
    end
    drain();
    end_test("colour mode");

    begin_test();
    for (int m = 2; m >= 0; m--) begin   // Red, green, blue alone
      channel_enable = 3'(1 << m);
      fill_random();
      run_frame(blocks, -1);
      drain();
    end
    channel_enable = 3'b111;
    end_test("channel masks");

    begin_test();
    hue_mode = 1'b1;
    repeat (2) begin
      fill_random();
      run_frame(blocks, -1);
    end
    fill_hue_cases();
    run_frame(blocks, -1);
    drain();
    hue_mode = 1'b0;
    end_test("hue mode");

    begin_test();
    out_ready = 1'b0;
    fill_random();
    run_frame(queue_depth, -1);   // Queue keeps the first words only
    repeat (flush_cycles) drive_cycle(1'b0, 1'b0, '0);
    assert (overflow == 1'b1)
      else begin
        $display("Error: overflow expected 0x1 got 0x%h", overflow);
        error_count++;
      end
    out_ready = 1'b1;
    drain();
    end_test("back-pressure");

    begin_test();
    frames_before = frame_count;
    repeat (3) begin
      fill_random();
      run_frame(blocks, -1);
    end
    drain();
    check_frames(frames_before + 3);
    fill_random();
    run_frame(blocks, 2);   // Switch off mid frame, frame still completes
    drain();
    check_frames(frames_before + 4);
    fill_random();
    run_frame(blocks, -1);
    drain();
    check_frames(frames_before + 4);
    end_test("frame counting");

    $display("Tests passed: %0d, failed: %0d, errors: %0d", pass_count, fail_count,
             error_count);
    if (fail_count == 0 && error_count == 0) $display("TESTBENCH PASSED");
    else $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps
// Testbench clock and reset
// Free-running pixel clock, synchronous reset held low for the first cycles
module tb_clock_gen #(
  parameter int period       = 100,   // ns
  parameter int reset_cycles = 2
) (
  output logic ccd_pixel_clk,
  output logic hps_fpga_reset_n
);

  initial begin
    ccd_pixel_clk = 1'b0;
    forever #(period / 2) ccd_pixel_clk = ~ccd_pixel_clk;
  end

  initial begin
    hps_fpga_reset_n = 1'b0;
    repeat (reset_cycles) @(posedge ccd_pixel_clk);
    #10 hps_fpga_reset_n = 1'b1;   // Same skew as the other inputs
  end

endmodule
